/* common/fetchPkg.sv */
`default_nettype none

package fetchPkg;

    // Basic widths
    typedef logic [15:0] word_t;     // Instruction, address or data
    typedef logic [2:0]  regAddr_t;  // One of eight registers
    typedef logic [4:0]  opcode_t;   // Instruction bits 15 to 11
    typedef logic [2:0]  immSel_t;   // Immediate format for execute
    typedef logic [1:0]  linkSel_t;  // Link register write mode
    typedef logic [1:0]  destSel_t;  // Which field names the destination

    // Load-use stall machine
    typedef enum logic {
        HZ_RUN,
        HZ_STALL
    } hazState_t;

    // Destination field choices
    localparam destSel_t DEST_RS   = 2'd0;  // Bits 10:8
    localparam destSel_t DEST_RD_R = 2'd1;  // Bits 4:2, register-register form
    localparam destSel_t DEST_R7   = 2'd2;  // Link register
    localparam destSel_t DEST_RD_I = 2'd3;  // Bits 7:5, immediate form

    localparam word_t NOP_INSTR   = 16'h0800;
    localparam word_t RESET_PC    = 16'h0000;
    localparam word_t SIIC_VECTOR = 16'h0002;

    // Instruction memory
    localparam int    ROM_DEPTH  = 256;
    localparam int    ROM_ADDR_W = $clog2(ROM_DEPTH);
    localparam string ROM_IMAGE  = "testbench/program.hex";

    // Opcodes
    localparam opcode_t OP_HALT = 5'b00000;
    localparam opcode_t OP_NOP  = 5'b00001;
    localparam opcode_t OP_SIIC = 5'b00010;
    localparam opcode_t OP_JR   = 5'b00101;
    localparam opcode_t OP_ADDI = 5'b01000;
    localparam opcode_t OP_BEQZ = 5'b01100;
    localparam opcode_t OP_ST   = 5'b10000;
    localparam opcode_t OP_LD   = 5'b10001;
    localparam opcode_t OP_ADD  = 5'b11011;

endpackage

`default_nettype wire

/* source/progCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module progCounter import fetchPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t brnchAddr,  // Resolved in execute
    input  logic  pcSel,
    input  word_t rs,
    input  word_t imm,
    input  logic  regJmp,
    input  logic  siic,
    input  logic  halt,
    input  logic  stall,
    output word_t pc
);

    word_t nextPc;
    logic  hold;

    // Redirect priority, highest first
    always_comb begin
        if (siic) begin
            nextPc = SIIC_VECTOR;
        end else if (pcSel) begin
            nextPc = brnchAddr;
        end else if (regJmp) begin
            nextPc = rs + imm;       // Register relative target
        end else begin
            nextPc = pc + 16'd2;     // Next halfword-aligned word
        end
    end

    // Stall and halt both freeze fetch
    assign hold = stall || halt;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!hold) begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* source/instrRom.sv */
`timescale 1ns/1ps
`default_nettype none

module instrRom import fetchPkg::*; (
    input  word_t addr,
    output word_t instr
);

    word_t mem [ROM_DEPTH];
    logic  inRange;

    // Unwritten words stay zero and decode as halt
    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            mem[i] = '0;
        end
        $readmemh(ROM_IMAGE, mem);
    end

    assign inRange = (addr[15:ROM_ADDR_W+1] == '0);

    // Word addressed, bit zero ignored
    assign instr = inRange ? mem[addr[ROM_ADDR_W:1]] : '0;

endmodule

`default_nettype wire

/* fetch/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode import fetchPkg::*; (
    input  opcode_t  opcode,
    output logic     regWrite,
    output destSel_t destSel,
    output logic     regJmp,
    output logic     memEnable,
    output logic     memWr,
    output logic     val2Reg,
    output logic     aluSel,
    output immSel_t  immSel,
    output logic     halt,
    output linkSel_t linkSel,
    output logic     ctrlErr,
    output logic     siic,
    output logic     bFlag
);

    // immSel encodings seen by execute
    //   0 none, 1 five-bit signed, 2 eight-bit signed
    // linkSel encodings
    //   0 no link, 1 write pc plus two to r7

    always_comb begin
        // Defaults describe a NOP
        regWrite  = 1'b0;
        destSel   = DEST_RS;
        regJmp    = 1'b0;
        memEnable = 1'b0;
        memWr     = 1'b0;
        val2Reg   = 1'b0;
        aluSel    = 1'b0;
        immSel    = 3'd0;
        halt      = 1'b0;
        linkSel   = 2'd0;
        ctrlErr   = 1'b0;
        siic      = 1'b0;
        bFlag     = 1'b0;

        case (opcode)
            OP_HALT: begin
                halt = 1'b1;
            end
            OP_NOP: begin
                // Nothing to do
            end
            OP_SIIC: begin
                siic = 1'b1;           // Trap to the exception vector
            end
            OP_ADDI: begin
                regWrite = 1'b1;
                destSel  = DEST_RD_I;
                aluSel   = 1'b1;       // Immediate operand
                immSel   = 3'd1;
            end
            OP_ST: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluSel    = 1'b1;      // Base plus offset
                immSel    = 3'd1;
            end
            OP_LD: begin
                regWrite  = 1'b1;
                destSel   = DEST_RD_I;
                memEnable = 1'b1;
                val2Reg   = 1'b1;      // Writeback takes memory data
                aluSel    = 1'b1;
                immSel    = 3'd1;
            end
            OP_JR: begin
                regWrite = 1'b1;
                destSel  = DEST_R7;    // Return address lands in r7
                regJmp   = 1'b1;
                linkSel  = 2'd1;
                immSel   = 3'd2;
            end
            OP_BEQZ: begin
                bFlag  = 1'b1;
                immSel = 3'd2;         // Branch displacement
            end
            OP_ADD: begin
                regWrite = 1'b1;
                destSel  = DEST_RD_R;
            end
            default: begin
                // Undefined opcode
                ctrlErr  = 1'b1;
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* fetch/hazardDetect.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardDetect import fetchPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    instr,       // Raw word from the ROM
    input  logic     issuedLoad,  // Issued instruction reads memory
    input  regAddr_t issuedDest,
    output logic     nop,
    output logic     stall
);

    hazState_t state;
    hazState_t nextState;
    logic      prevLoad;
    regAddr_t  prevDest;
    logic      srcMatch;
    logic      loadUse;

    // Track what issued last cycle
    // A NOP issues during the stall, which clears prevLoad
    always_ff @(posedge clk) begin
        if (rst) begin
            prevLoad <= 1'b0;
        end else begin
            prevLoad <= issuedLoad;
        end
    end

    always_ff @(posedge clk) begin
        prevDest <= issuedDest;
    end

    // Either source field may name the load target
    assign srcMatch = (instr[10:8] == prevDest) || (instr[7:5] == prevDest);
    assign loadUse  = prevLoad && srcMatch;

    always_comb begin
        nextState = state;
        case (state)
            HZ_RUN: begin
                if (loadUse) begin
                    nextState = HZ_STALL;
                end
            end
            HZ_STALL: begin
                nextState = HZ_RUN;    // Original instruction issues now
            end
            default: begin
                nextState = HZ_RUN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HZ_RUN;
        end else begin
            state <= nextState;
        end
    end

    // Bubble and pc hold go together
    assign stall = (state == HZ_RUN) && loadUse;
    assign nop   = stall;

endmodule

`default_nettype wire

/* fetch/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch import fetchPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    brnchAddr,
    input  logic     pcSel,
    input  word_t    imm,
    input  word_t    rs,
    output word_t    pc,
    output word_t    instrOut,
    output logic     regWrite,
    output regAddr_t writeRegAddr,
    output logic     memEnable,
    output logic     memWr,
    output logic     val2Reg,
    output logic     aluSel,
    output immSel_t  immSel,
    output linkSel_t linkSel,
    output logic     ctrlErr,
    output logic     bFlag,
    output logic     halt,
    output logic     siic,
    output logic     regJmp
);

    word_t    rawInstr;
    word_t    issuedInstr;
    destSel_t destSel;
    logic     hazNop;
    logic     hazStall;
    logic     issuedLoad;

    progCounter progCnt (
        .clk       (clk),
        .rst       (rst),
        .brnchAddr (brnchAddr),
        .pcSel     (pcSel),
        .rs        (rs),
        .imm       (imm),
        .regJmp    (regJmp),
        .siic      (siic),
        .halt      (halt),
        .stall     (hazStall),
        .pc        (pc)
    );

    instrRom instrMem (
        .addr  (pc),
        .instr (rawInstr)
    );

    // Bubble in a NOP while the load result is pending
    assign issuedInstr = hazNop ? NOP_INSTR : rawInstr;
    assign instrOut    = issuedInstr;

    instrDecode ctrl (
        .opcode    (issuedInstr[15:11]),
        .regWrite  (regWrite),
        .destSel   (destSel),
        .regJmp    (regJmp),
        .memEnable (memEnable),
        .memWr     (memWr),
        .val2Reg   (val2Reg),
        .aluSel    (aluSel),
        .immSel    (immSel),
        .halt      (halt),
        .linkSel   (linkSel),
        .ctrlErr   (ctrlErr),
        .siic      (siic),
        .bFlag     (bFlag)
    );

    // Destination register field
    always_comb begin
        case (destSel)
            DEST_RS:   writeRegAddr = issuedInstr[10:8];
            DEST_RD_R: writeRegAddr = issuedInstr[4:2];
            DEST_R7:   writeRegAddr = 3'd7;
            DEST_RD_I: writeRegAddr = issuedInstr[7:5];
            default:   writeRegAddr = issuedInstr[4:2];
        endcase
    end

    assign issuedLoad = memEnable && !memWr;  // Reads memory, so a load

    hazardDetect hazDet (
        .clk        (clk),
        .rst        (rst),
        .instr      (rawInstr),
        .issuedLoad (issuedLoad),
        .issuedDest (writeRegAddr),
        .nop        (hazNop),
        .stall      (hazStall)
    );

endmodule

`default_nettype wire

/* testbench/fetch_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchAssert import fetchPkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input logic        nop,
    input logic        halt,
    input word_t       pc,
    input word_t       instrOut,
    input word_t       rawInstr,
    input regAddr_t    writeRegAddr,
    input logic [14:0] ctrlFlags
);

    int failCount = 0;  // Read by the testbench at the end

    // The held instruction issues right after its bubble
    heldIssue: assert property (@(posedge clk) disable iff (rst)
            nop |=> (instrOut == $past(rawInstr)))
        else begin
            $error("held instruction did not issue after the bubble");
            failCount++;
        end

    // Only one bubble per load-use pair
    singleStall: assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
        else begin
            $error("stall held for two cycles");
            failCount++;
        end

    pcHeld: assert property (@(posedge clk) disable iff (rst) (stall || halt) |=> $stable(pc))
        else begin
            $error("pc moved after stall or halt");
            failCount++;
        end

    knownOutputs: assert property (@(posedge clk) disable iff (rst)
            !$isunknown({pc, instrOut, writeRegAddr, ctrlFlags, stall}))
        else begin
            $error("unknown value on a fetch output");
            failCount++;
        end

endmodule

bind fetch fetchAssert checks (
    .clk          (clk),
    .rst          (rst),
    .stall        (hazStall),
    .nop          (hazNop),
    .halt         (halt),
    .pc           (pc),
    .instrOut     (instrOut),
    .rawInstr     (rawInstr),
    .writeRegAddr (writeRegAddr),
    .ctrlFlags    ({regWrite, memEnable, memWr, val2Reg, aluSel, immSel, linkSel,
                    ctrlErr, bFlag, halt, siic, regJmp})
);

`default_nettype wire

/* testbench/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetchPkg::*; ();

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 3;
    localparam int    DRIVE_DELAY  = 1;
    localparam int    RAND_SEED    = 50;
    localparam string CASE_FILE    = "testbench/fetchCases.txt";

    // {regWrite, memEnable, memWr, val2Reg, aluSel, immSel, linkSel,
    //  ctrlErr, bFlag, halt, siic, regJmp}
    typedef logic [14:0] ctrlVec_t;

    logic     clk;
    logic     rst;
    word_t    brnchAddr;
    logic     pcSel;
    word_t    imm;
    word_t    rs;
    word_t    pc;
    word_t    instrOut;
    logic     regWrite;
    regAddr_t writeRegAddr;
    logic     memEnable;
    logic     memWr;
    logic     val2Reg;
    logic     aluSel;
    immSel_t  immSel;
    linkSel_t linkSel;
    logic     ctrlErr;
    logic     bFlag;
    logic     halt;
    logic     siic;
    logic     regJmp;

    // One entry per case line
    logic     caseSel   [$];
    word_t    caseBrnch [$];
    logic     caseRnd   [$];   // rs and imm unused, fill randomly
    word_t    caseRs    [$];
    word_t    caseImm   [$];
    word_t    expPc     [$];
    word_t    expInstr  [$];
    regAddr_t expReg    [$];
    ctrlVec_t expCtrl   [$];

    int       numCases;
    logic     casesLoaded = 1'b0;
    ctrlVec_t actCtrl;

    fetch i_dut (
        .clk          (clk),
        .rst          (rst),
        .brnchAddr    (brnchAddr),
        .pcSel        (pcSel),
        .imm          (imm),
        .rs           (rs),
        .pc           (pc),
        .instrOut     (instrOut),
        .regWrite     (regWrite),
        .writeRegAddr (writeRegAddr),
        .memEnable    (memEnable),
        .memWr        (memWr),
        .val2Reg      (val2Reg),
        .aluSel       (aluSel),
        .immSel       (immSel),
        .linkSel      (linkSel),
        .ctrlErr      (ctrlErr),
        .bFlag        (bFlag),
        .halt         (halt),
        .siic         (siic),
        .regJmp       (regJmp)
    );

    assign actCtrl = {regWrite, memEnable, memWr, val2Reg, aluSel, immSel, linkSel,
                      ctrlErr, bFlag, halt, siic, regJmp};

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic checkWord(input string name, input word_t expVal, input word_t actVal);
        if (actVal !== expVal) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkReg(input string name, input regAddr_t expVal, input regAddr_t actVal);
        if (actVal !== expVal) begin
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expVal, actVal);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkCtrl(input string name, input ctrlVec_t expVal, input ctrlVec_t actVal);
        if (actVal !== expVal) begin
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expVal, actVal);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic loadCases();
        int    fd;
        int    n;
        string line;
        word_t fSel, fBrnch, fRnd, fRs, fImm, fPc, fInstr, fReg, fCtrl;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", CASE_FILE);
            $display("sim failed");
            $fatal(1, "no case file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        fSel, fBrnch, fRnd, fRs, fImm, fPc, fInstr, fReg, fCtrl);
            if (n == 9) begin
                caseSel.push_back(fSel[0]);
                caseBrnch.push_back(fBrnch);
                caseRnd.push_back(fRnd[0]);
                caseRs.push_back(fRs);
                caseImm.push_back(fImm);
                expPc.push_back(fPc);
                expInstr.push_back(fInstr);
                expReg.push_back(fReg[2:0]);
                expCtrl.push_back(fCtrl[14:0]);
            end else if (n > 0) begin
                $display("Malformed line in the case file: %s", line);
                $display("sim failed");
                $fatal(1, "bad case line");
            end
        end
        $fclose(fd);
        numCases = caseSel.size();
    endtask

    task automatic applyCase(input int idx);
        pcSel     = caseSel[idx];
        brnchAddr = caseBrnch[idx];
        if (caseRnd[idx]) begin
            rs  = word_t'($urandom());   // No jump taken here
            imm = word_t'($urandom());
        end else begin
            rs  = caseRs[idx];
            imm = caseImm[idx];
        end
    endtask

    task automatic checkCase(input int idx);
        checkWord($sformatf("pc (case %0d)", idx), expPc[idx], pc);
        checkWord($sformatf("instrOut (case %0d)", idx), expInstr[idx], instrOut);
        checkReg($sformatf("writeRegAddr (case %0d)", idx), expReg[idx], writeRegAddr);
        checkCtrl($sformatf("control flags (case %0d)", idx), expCtrl[idx], actCtrl);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        pcSel     = 1'b0;
        brnchAddr = '0;
        rs        = '0;
        imm       = '0;
        void'($urandom(RAND_SEED));
        loadCases();
        casesLoaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Drive after the edge, sample just before the next one
        for (int i = 0; i < numCases; i++) begin
            applyCase(i);
            #(CLK_PERIOD - 2 * DRIVE_DELAY);
            checkCase(i);
            @(posedge clk);
            #DRIVE_DELAY;
        end

        if (i_dut.checks.failCount == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("%0d assertion failures during the run", i_dut.checks.failCount);
            $display("sim failed");
            $fatal(1, "assertion failures");
        end
    end

    // Watchdog
    initial begin
        wait (casesLoaded === 1'b1);
        #((numCases + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("Run did not finish its %0d cases in time", numCases);
        $display("sim failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* testbench/fetchCases.txt */
// Inputs: pcSel brnchAddr rnd rs imm (rnd 1 fills rs and imm randomly)
// Expected: pc instrOut writeRegAddr ctrl, ctrl as hex of the packed control flags
0 0000 1 0000 0000 0000 4225 1 4480
0 0000 1 0000 0000 0002 0800 0 0000
0 0000 1 0000 0000 0004 D94C 3 4000
0 0000 1 0000 0000 0006 8283 2 3480
0 0000 1 0000 0000 0008 8962 3 6C80
0 0000 1 0000 0000 000A 0800 0 0000
0 0000 1 0000 0000 000A DB50 4 4000
0 0000 1 0000 0000 000C 8A81 4 6C80
0 0000 1 0000 0000 000E D954 5 4000
1 0020 1 0000 0000 0010 6607 6 0108
0 0000 1 0000 0000 0020 FAA5 2 0010
0 0000 0 0020 0008 0022 2908 7 4121
1 0030 0 0100 0004 0028 2B04 7 4121
1 0050 1 0000 0000 0030 1000 0 0002
1 0040 1 0000 0000 0002 0800 0 0000
0 0000 1 0000 0000 0040 89A4 5 6C80
0 0000 1 0000 0000 0042 0800 0 0000
0 0000 1 0000 0000 0042 DAB8 6 4000
0 0000 1 0000 0000 0044 0000 0 0004
1 0010 1 0000 0000 0044 0000 0 0004
0 0000 1 0000 0000 0044 0000 0 0004
0 0000 1 0000 0000 0044 0000 0 0004

/* testbench/program.hex */
// One 16-bit instruction word per line, @ lines set the word address
4225
0800
D94C
8283
8962
DB50
8A81
D954
6607
@10
FAA5
2908
@14
2B04
@18
1000
@20
89A4
DAB8
0000

/* sources.f */
common/fetchPkg.sv
source/progCounter.sv
source/instrRom.sv
fetch/instrDecode.sv
fetch/hazardDetect.sv
fetch/fetch.sv
testbench/fetch_assert.sv
testbench/fetch_tb.sv
